// File: include/lc3_config.svh
// core-wide constants for the LC-3
// widths, register count, reset PC, link register and IR field positions
`ifndef LC3_CONFIG_SVH
`define LC3_CONFIG_SVH

// word and address width
`define LC3_WORD_W      16
`define LC3_REG_COUNT   8
`define LC3_RESET_PC    16'h0000
// JSR/JSRR return address goes here
`define LC3_LINK_REG    3'd7

// instruction field positions
`define LC3_OP_MSB      15
`define LC3_OP_LSB      12
`define LC3_DR_LSB      9
`define LC3_SR1_LSB     6
`define LC3_IMM_FLAG    5
`define LC3_JSR_FLAG    11

`endif

// File: source/lc3_pkg.sv
// shared types for the LC-3 core
// word/index vectors, opcodes, FSM states and mux selects
`include "lc3_config.svh"

package lc3_pkg;

    typedef logic [`LC3_WORD_W-1:0] word_t;
    typedef logic [$clog2(`LC3_REG_COUNT)-1:0] reg_idx_t;

    // full opcode map, unused entries decode as no-ops
    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LD   = 4'b0010,
        OP_ST   = 4'b0011,
        OP_JSR  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_RTI  = 4'b1000,
        OP_NOT  = 4'b1001,
        OP_LDI  = 4'b1010,
        OP_STI  = 4'b1011,
        OP_JMP  = 4'b1100,
        OP_RES  = 4'b1101,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } opcode_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_ADDR,
        S_MEM_REQ,
        S_MEM_WAIT
    } ctrl_state_t;

    // next PC source
    typedef enum logic [1:0] {PC_INC, PC_OFFSET9, PC_OFFSET11, PC_BASE} pc_sel_t;

    // register write source
    typedef enum logic [1:0] {RD_ALU, RD_MEM, RD_LEA, RD_PC} reg_data_sel_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT} alu_op_t;

endpackage

// File: source/lc3_ctrl_if.sv
// control/datapath strobe bundle
// control drives the load strobes and selects, datapath returns decode info
`timescale 1ns/100ps

interface lc3_ctrl_if import lc3_pkg::*; ();

    // from datapath
    opcode_t       opcode;
    logic          branch_taken;

    // from control
    logic          ld_ir;
    logic          ld_pc;
    pc_sel_t       pc_sel;
    logic          ld_mar;
    logic          reg_we;
    reg_data_sel_t reg_data_sel;
    alu_op_t       alu_op;
    logic          ld_cc;
    // PC drives the memory address, else MAR
    logic          fetch_phase;

    modport control (
        input  opcode, branch_taken,
        output ld_ir, ld_pc, pc_sel, ld_mar, reg_we, reg_data_sel,
        output alu_op, ld_cc, fetch_phase
    );

    modport datapath (
        output opcode, branch_taken,
        input  ld_ir, ld_pc, pc_sel, ld_mar, reg_we, reg_data_sel,
        input  alu_op, ld_cc, fetch_phase
    );

endinterface

// File: source/lc3_reg_file.sv
// general register file, two async read ports and one clocked write port
`timescale 1ns/100ps
`include "lc3_config.svh"

module lc3_reg_file import lc3_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  reg_idx_t rd_a_idx,
    input  reg_idx_t rd_b_idx,
    input  word_t    wr_data,
    output word_t    rd_a_data,
    output word_t    rd_b_data
);

    word_t regs [`LC3_REG_COUNT];

    // write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LC3_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // read ports, no bypass
    // a write lands after the edge, same-cycle reads see the old value
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];

endmodule

// File: source/lc3_alu_cc.sv
// ALU, N/Z/P condition-code register and the branch condition test
`timescale 1ns/100ps

module lc3_alu_cc import lc3_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    input  word_t      cc_data,
    input  logic       ld_cc,
    input  logic [2:0] nzp_mask,
    output word_t      result,
    output logic       branch_taken
);

    // {n, z, p}
    logic [2:0] cc;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_AND: result = a & b;
            ALU_NOT: result = ~a;
            default: result = a + b;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // condition codes

    // cc_data is whatever goes to the register file this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= 3'b000;
        end else if (ld_cc) begin
            cc[2] <= cc_data[$bits(word_t)-1];
            cc[1] <= (cc_data == '0);
            cc[0] <= !cc_data[$bits(word_t)-1] && (cc_data != '0);
        end
    end

    // mask comes straight from IR[11:9]
    assign branch_taken = |(cc & nzp_mask);

endmodule

// File: source/lc3_datapath.sv
// PC, IR and MAR, field decode, sign extension and address adders
// register write mux and memory address/data outputs
`timescale 1ns/100ps
`include "lc3_config.svh"

module lc3_datapath import lc3_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    lc3_ctrl_if.datapath    dp,
    output word_t           mem_req_addr,
    output word_t           mem_req_wdata,
    input  word_t           mem_rsp_data
);

    word_t    pc;
    word_t    ir;
    word_t    mar;

    word_t    sext_imm5;
    word_t    sext_off6;
    word_t    sext_off9;
    word_t    sext_off11;
    word_t    pc_off9;
    word_t    pc_off11;
    word_t    base_off6;
    word_t    next_pc;

    reg_idx_t wr_idx;
    reg_idx_t rd_b_idx;
    word_t    rd_a_data;
    word_t    rd_b_data;
    word_t    wr_data;
    word_t    alu_b;
    word_t    alu_result;
    logic     is_store;

    ////////////////////////////////////////////////////////////////////////////
    // field decode

    assign dp.opcode = opcode_t'(ir[`LC3_OP_MSB:`LC3_OP_LSB]);
    assign is_store  = (dp.opcode == OP_ST) || (dp.opcode == OP_STR);

    // sign extension of every immediate and offset
    assign sext_imm5  = {{11{ir[4]}}, ir[4:0]};
    assign sext_off6  = {{10{ir[5]}}, ir[5:0]};
    assign sext_off9  = {{7{ir[8]}}, ir[8:0]};
    assign sext_off11 = {{5{ir[10]}}, ir[10:0]};

    // pc is already incremented when these are used
    assign pc_off9   = pc + sext_off9;
    assign pc_off11  = pc + sext_off11;
    assign base_off6 = rd_a_data + sext_off6;

    ////////////////////////////////////////////////////////////////////////////
    // register file and ALU

    // JSR/JSRR always link through R7
    assign wr_idx   = (dp.opcode == OP_JSR) ? `LC3_LINK_REG : ir[`LC3_DR_LSB +: 3];
    // stores read the SR field on port b, ALU ops read SR2
    assign rd_b_idx = is_store ? ir[`LC3_DR_LSB +: 3] : ir[2:0];
    assign alu_b    = ir[`LC3_IMM_FLAG] ? sext_imm5 : rd_b_data;

    always_comb begin
        case (dp.reg_data_sel)
            RD_ALU:  wr_data = alu_result;
            RD_MEM:  wr_data = mem_rsp_data;
            RD_LEA:  wr_data = pc_off9;
            RD_PC:   wr_data = pc;
            default: wr_data = alu_result;
        endcase
    end

    lc3_reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .we        (dp.reg_we),
        .wr_idx    (wr_idx),
        .rd_a_idx  (ir[`LC3_SR1_LSB +: 3]),
        .rd_b_idx  (rd_b_idx),
        .wr_data   (wr_data),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

    // cc follows the register write data
    lc3_alu_cc u_alu_cc (
        .clk          (clk),
        .reset        (reset),
        .op           (dp.alu_op),
        .a            (rd_a_data),
        .b            (alu_b),
        .cc_data      (wr_data),
        .ld_cc        (dp.ld_cc),
        .nzp_mask     (ir[11:9]),
        .result       (alu_result),
        .branch_taken (dp.branch_taken)
    );

    ////////////////////////////////////////////////////////////////////////////
    // PC, IR, MAR

    always_comb begin
        case (dp.pc_sel)
            PC_INC:      next_pc = pc + 16'd1;
            PC_OFFSET9:  next_pc = pc_off9;
            // JSRR shares the opcode, bit 11 clear means base register
            PC_OFFSET11: next_pc = ir[`LC3_JSR_FLAG] ? pc_off11 : rd_a_data;
            PC_BASE:     next_pc = rd_a_data;
            default:     next_pc = pc + 16'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `LC3_RESET_PC;
            ir <= '0;
        end else begin
            if (dp.ld_pc) begin
                pc <= next_pc;
            end
            if (dp.ld_ir) begin
                ir <= mem_rsp_data;
            end
        end
    end

    // LDR/STR are base-relative, LD/ST are pc-relative
    always_ff @(posedge clk) begin
        if (dp.ld_mar) begin
            mar <= ((dp.opcode == OP_LDR) || (dp.opcode == OP_STR)) ? base_off6 : pc_off9;
        end
    end

    assign mem_req_addr  = dp.fetch_phase ? pc : mar;
    assign mem_req_wdata = rd_b_data;

endmodule

// File: source/lc3_control.sv
// multicycle sequencer FSM for the LC-3 core
// fetch, decode, execute and memory access over a valid/ready port
`timescale 1ns/100ps

module lc3_control import lc3_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    lc3_ctrl_if.control    ctrl,
    output logic           mem_req_valid,
    output logic           mem_req_write,
    input  logic           mem_req_ready,
    input  logic           mem_rsp_valid
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic accept;
    logic is_exec;
    logic is_load;
    logic is_store;

    // request taken on this edge
    assign accept = mem_req_valid && mem_req_ready;

    ////////////////////////////////////////////////////////////////////////////
    // opcode classes

    always_comb begin
        is_exec  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (ctrl.opcode)
            OP_ADD, OP_AND, OP_NOT, OP_LEA, OP_BR, OP_JMP, OP_JSR: is_exec = 1'b1;
            OP_LD, OP_LDR:                                         is_load = 1'b1;
            OP_ST, OP_STR:                                         is_store = 1'b1;
            // RTI, reserved and the dropped ops fall through as no-ops
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state

    always_comb begin
        next_state = state;
        case (state)
            S_FETCH:      if (accept) next_state = S_FETCH_WAIT;
            S_FETCH_WAIT: if (mem_rsp_valid) next_state = S_DECODE;
            S_DECODE: begin
                if (is_exec) begin
                    next_state = S_EXECUTE;
                end else if (is_load || is_store) begin
                    next_state = S_ADDR;
                end else begin
                    next_state = S_FETCH;
                end
            end
            S_EXECUTE:    next_state = S_FETCH;
            S_ADDR:       next_state = S_MEM_REQ;
            S_MEM_REQ:    if (accept) next_state = S_MEM_WAIT;
            S_MEM_WAIT:   if (mem_rsp_valid) next_state = S_FETCH;
            default:      next_state = S_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= next_state;
        end
    end

    // registered request, held low through reset
    // stays up until accept moves the FSM out of the request state
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_valid <= 1'b0;
            mem_req_write <= 1'b0;
        end else begin
            mem_req_valid <= (next_state == S_FETCH) || (next_state == S_MEM_REQ);
            mem_req_write <= (next_state == S_MEM_REQ) && is_store;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // per-state strobes

    always_comb begin
        ctrl.ld_ir        = 1'b0;
        ctrl.ld_pc        = 1'b0;
        ctrl.pc_sel       = PC_INC;
        ctrl.ld_mar       = 1'b0;
        ctrl.reg_we       = 1'b0;
        ctrl.reg_data_sel = RD_ALU;
        ctrl.alu_op       = ALU_ADD;
        ctrl.ld_cc        = 1'b0;
        ctrl.fetch_phase  = (state == S_FETCH);
        case (state)
            // pc bumps as the fetch is accepted
            S_FETCH:      ctrl.ld_pc = accept;
            S_FETCH_WAIT: ctrl.ld_ir = mem_rsp_valid;
            S_EXECUTE: begin
                case (ctrl.opcode)
                    OP_ADD, OP_AND, OP_NOT: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.ld_cc  = 1'b1;
                        if (ctrl.opcode == OP_AND) begin
                            ctrl.alu_op = ALU_AND;
                        end else if (ctrl.opcode == OP_NOT) begin
                            ctrl.alu_op = ALU_NOT;
                        end
                    end
                    OP_LEA: begin
                        ctrl.reg_we       = 1'b1;
                        ctrl.reg_data_sel = RD_LEA;
                        ctrl.ld_cc        = 1'b1;
                    end
                    // not taken leaves the pc alone
                    OP_BR: begin
                        ctrl.ld_pc  = ctrl.branch_taken;
                        ctrl.pc_sel = ctrl.branch_taken ? PC_OFFSET9 : PC_INC;
                    end
                    OP_JMP: begin
                        ctrl.ld_pc  = 1'b1;
                        ctrl.pc_sel = PC_BASE;
                    end
                    // link and jump on the same edge
                    OP_JSR: begin
                        ctrl.ld_pc        = 1'b1;
                        ctrl.pc_sel       = PC_OFFSET11;
                        ctrl.reg_we       = 1'b1;
                        ctrl.reg_data_sel = RD_PC;
                    end
                    default: ;
                endcase
            end
            S_ADDR:       ctrl.ld_mar = 1'b1;
            // load data and cc land with the response
            S_MEM_WAIT: begin
                ctrl.reg_we       = mem_rsp_valid && is_load;
                ctrl.ld_cc        = mem_rsp_valid && is_load;
                ctrl.reg_data_sel = RD_MEM;
            end
            default: ;
        endcase
    end

endmodule

// File: source/lc3_core.sv
// LC-3 core top level
// control FSM and datapath joined by the strobe interface
`timescale 1ns/100ps

module lc3_core import lc3_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    // memory request
    output logic  mem_req_valid,
    output logic  mem_req_write,
    output word_t mem_req_addr,
    output word_t mem_req_wdata,
    input  logic  mem_req_ready,

    // memory response
    input  logic  mem_rsp_valid,
    input  word_t mem_rsp_data
);

    lc3_ctrl_if u_ctrl_if ();

    // sequencer owns valid/write, datapath owns address/data
    lc3_control u_control (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (u_ctrl_if.control),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid)
    );

    lc3_datapath u_datapath (
        .clk           (clk),
        .reset         (reset),
        .dp            (u_ctrl_if.datapath),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

// File: testbench/lc3_mem_model.sv
// word memory for the core testbench
// valid/ready request port with outside stall controls, reports accepted writes
`timescale 1ns/100ps

module lc3_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [15:0] req_addr,
    input  logic [15:0] req_wdata,
    output logic        req_ready,
    output logic        rsp_valid,
    output logic [15:0] rsp_data,
    // cycles of withheld ready, cycles from accept to response
    input  int          ready_stall,
    input  int          rsp_delay,
    output logic        write_seen,
    output logic [15:0] write_addr,
    output logic [15:0] write_data
);

    logic [15:0] mem [0:65535];
    logic        busy;
    int          stall_cnt;
    int          delay_cnt;

    always @(posedge clk) begin
        write_seen <= 1'b0;
        rsp_valid  <= 1'b0;
        if (reset) begin
            req_ready <= 1'b0;
            rsp_data  <= 16'h0000;
            busy      <= 1'b0;
            stall_cnt <= 0;
            delay_cnt <= 0;
        end else if (req_valid && req_ready) begin
            // accepted on this edge
            req_ready <= 1'b0;
            busy      <= 1'b1;
            delay_cnt <= 1;
            stall_cnt <= 0;
            if (req_write) begin
                mem[req_addr] = req_wdata;
                write_seen <= 1'b1;
                write_addr <= req_addr;
                write_data <= req_wdata;
                rsp_data   <= 16'h0000;
            end else begin
                rsp_data <= mem[req_addr];
            end
        end else if (busy) begin
            // one response pulse per accepted request
            if (delay_cnt >= rsp_delay) begin
                rsp_valid <= 1'b1;
                busy      <= 1'b0;
            end else begin
                delay_cnt <= delay_cnt + 1;
            end
        end else if (req_valid) begin
            if (stall_cnt >= ready_stall) begin
                req_ready <= 1'b1;
            end else begin
                stall_cnt <= stall_cnt + 1;
            end
        end
    end

endmodule

// File: testbench/lc3_core_tb.sv
// testbench for the LC-3 core
// clock, reset, program builders, LCG, directed tests and write checks
`timescale 1ns/100ps

module lc3_core_tb import lc3_pkg::*; ();

    localparam int SLOT_BASE = 16'h00d0;
    localparam int DATA_BASE = 16'h0080;
    localparam int OUT_BASE  = 16'h0090;
    localparam int TIMEOUT   = 5000;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        mem_req_valid;
    logic        mem_req_write;
    logic [15:0] mem_req_addr;
    logic [15:0] mem_req_wdata;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    logic [15:0] mem_rsp_data;
    logic        write_seen;
    logic [15:0] write_addr;
    logic [15:0] write_data;
    int          ready_stall = 0;
    int          rsp_delay = 1;

    logic        random_stalls = 1'b0;
    logic [31:0] stall_state = 32'h3f1c;
    logic [31:0] data_state;
    int          load_addr;
    int          slot;
    // {addr, data} per write
    logic [31:0] exp_q[$];
    logic [31:0] got_q[$];

    always #5 clk = ~clk;

    lc3_core u_lc3_core (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    lc3_mem_model u_mem_model (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (mem_req_valid),
        .req_write   (mem_req_write),
        .req_addr    (mem_req_addr),
        .req_wdata   (mem_req_wdata),
        .req_ready   (mem_req_ready),
        .rsp_valid   (mem_rsp_valid),
        .rsp_data    (mem_rsp_data),
        .ready_stall (ready_stall),
        .rsp_delay   (rsp_delay),
        .write_seen  (write_seen),
        .write_addr  (write_addr),
        .write_data  (write_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // new stall controls drawn every cycle when enabled
    always @(negedge clk) begin
        if (random_stalls) begin
            stall_state = lcg_next(stall_state);
            ready_stall <= int'(stall_state[17:16]);
            rsp_delay   <= 1 + int'(stall_state[21:20]);
        end else begin
            ready_stall <= 0;
            rsp_delay   <= 1;
        end
    end

    // write monitor
    always @(negedge clk) begin
        if (write_seen) begin
            got_q.push_back({write_addr, write_data});
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoders

    function automatic logic [15:0] alu_rrr(logic [3:0] op, int dr, int sr1, int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic logic [15:0] alu_rri(logic [3:0] op, int dr, int sr1, int imm);
        return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
    endfunction

    function automatic logic [15:0] not_instr(int dr, int sr);
        return {4'b1001, 3'(dr), 3'(sr), 6'b111111};
    endfunction

    function automatic logic [15:0] branch(int nzp, int off);
        return {4'b0000, 3'(nzp), 9'(off)};
    endfunction

    function automatic logic [15:0] jump(int base);
        return {4'b1100, 3'b000, 3'(base), 6'b000000};
    endfunction

    function automatic logic [15:0] jsr_rel(int off);
        return {4'b0100, 1'b1, 11'(off)};
    endfunction

    function automatic logic [15:0] jsr_reg(int base);
        return {4'b0100, 3'b000, 3'(base), 6'b000000};
    endfunction

    function automatic logic [15:0] pc_rel(logic [3:0] op, int r, int off);
        return {op, 3'(r), 9'(off)};
    endfunction

    function automatic logic [15:0] base_rel(logic [3:0] op, int r, int base, int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    // {n, z, p} of a written value
    function automatic logic [2:0] flags_of(logic [15:0] v);
        return {v[15], v == 16'h0000, !v[15] && (v != 16'h0000)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // program building

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic emit(input logic [15:0] w);
        u_mem_model.mem[load_addr] = w;
        load_addr++;
    endtask

    task automatic emit_st(input int sr, input int target);
        emit(pc_rel(OP_ST, sr, target - (load_addr + 1)));
    endtask

    task automatic expect_write(input int addr, input logic [15:0] data);
        exp_q.push_back({16'(addr), data});
    endtask

    task automatic store_result(input int sr, input logic [15:0] value);
        emit_st(sr, slot);
        expect_write(slot, value);
        slot++;
    endtask

    // forward branch stores the R6 marker when taken and R0 when not
    task automatic fwd_check(input int mask, input logic [15:0] value);
        emit(branch(mask, 2));
        emit_st(0, slot);
        emit(branch(7, 1));
        emit_st(6, slot);
        expect_write(slot, ((flags_of(value) & 3'(mask)) != 0) ? 16'd15 : 16'd0);
        slot++;
    endtask

    // jump ahead and branch back onto the taken marker
    task automatic back_check(input int mask, input logic [15:0] value);
        emit(branch(7, 2));
        emit_st(6, slot);
        emit(branch(7, 2));
        emit(branch(mask, -3));
        emit_st(0, slot);
        expect_write(slot, ((flags_of(value) & 3'(mask)) != 0) ? 16'd15 : 16'd0);
        slot++;
    endtask

    task automatic flag_checks(input logic [15:0] value);
        fwd_check(4, value);
        fwd_check(2, value);
        fwd_check(1, value);
    endtask

    // R7 scratch op that leaves flags other than those of value
    task automatic preset_flags(input logic [15:0] value);
        if (flags_of(value) == 3'b001) begin
            emit(alu_rri(OP_AND, 7, 0, 0));
        end else begin
            emit(alu_rri(OP_ADD, 7, 6, 0));
        end
    endtask

    task automatic halt();
        emit(branch(7, -1));
    endtask

    task automatic begin_test();
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 65536; i++) begin
            u_mem_model.mem[i] = 16'(i) ^ 16'ha5c3;
        end
        load_addr = 0;
        slot = SLOT_BASE;
        exp_q.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run and check

    task automatic hold_reset();
        reset = 1'b1;
        got_q.delete();
        repeat (16) begin
            @(negedge clk);
            assert (!mem_req_valid)
                else fail_run("[FAIL] mem_req_valid exp 0 got 1 during reset");
        end
        reset = 1'b0;
    endtask

    task automatic wait_writes(input int count);
        int cycles;
        cycles = 0;
        while (got_q.size() < count && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (got_q.size() < count) begin
            fail_run($sformatf("timed out waiting for %0d memory writes, only %0d seen",
                count, got_q.size()));
        end
    endtask

    task automatic run_program();
        hold_reset();
        wait_writes(exp_q.size());
        // no late writes while idling at the halt loop
        repeat (20) @(negedge clk);
        assert (got_q.size() == exp_q.size())
            else fail_run($sformatf("[FAIL] write count exp %h got %h",
                exp_q.size(), got_q.size()));
        foreach (exp_q[i]) begin
            assert (got_q[i][31:16] == exp_q[i][31:16])
                else fail_run($sformatf("[FAIL] mem_req_addr exp %h got %h",
                    exp_q[i][31:16], got_q[i][31:16]));
            assert (got_q[i][15:0] == exp_q[i][15:0])
                else fail_run($sformatf("[FAIL] mem_req_wdata exp %h got %h",
                    exp_q[i][15:0], got_q[i][15:0]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic reset_fetch();
        int cycles;
        begin_test();
        emit(alu_rri(OP_ADD, 1, 0, 1));
        halt();
        hold_reset();
        cycles = 0;
        while (!(mem_req_valid && mem_req_ready) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!(mem_req_valid && mem_req_ready)) begin
            fail_run("no memory request was accepted after reset");
        end
        assert (!mem_req_write)
            else fail_run("[FAIL] mem_req_write exp 0 got 1");
        assert (mem_req_addr == 16'h0000)
            else fail_run($sformatf("[FAIL] mem_req_addr exp 0000 got %h", mem_req_addr));
    endtask

    task automatic alu_flags();
        logic [15:0] v6;
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        logic [15:0] v4;
        logic [15:0] v5;
        v6 = 16'd15;
        v1 = v6 + 16'hfff0;
        v2 = v1 + v6;
        v3 = v2 & 16'h0001;
        v4 = v1 & 16'hfffe;
        v5 = ~v4;
        begin_test();
        emit(alu_rri(OP_ADD, 6, 0, 15));
        store_result(6, v6);
        flag_checks(v6);
        // negative immediate
        emit(alu_rri(OP_ADD, 1, 6, -16));
        store_result(1, v1);
        flag_checks(v1);
        emit(alu_rrr(OP_ADD, 2, 1, 6));
        store_result(2, v2);
        flag_checks(v2);
        emit(alu_rri(OP_AND, 3, 2, 1));
        store_result(3, v3);
        flag_checks(v3);
        emit(alu_rri(OP_AND, 4, 1, -2));
        store_result(4, v4);
        flag_checks(v4);
        emit(not_instr(5, 4));
        store_result(5, v5);
        flag_checks(v5);
        halt();
        run_program();
    endtask

    task automatic branch_paths();
        int vals[3];
        int masks[4];
        vals = '{-3, 0, 5};
        masks = '{4, 2, 1, 7};
        begin_test();
        emit(alu_rri(OP_ADD, 6, 0, 15));
        foreach (vals[v]) begin
            emit(alu_rri(OP_ADD, 1, 0, vals[v]));
            foreach (masks[m]) begin
                fwd_check(masks[m], 16'(vals[v]));
                back_check(masks[m], 16'(vals[v]));
            end
        end
        halt();
        run_program();
    endtask

    // subroutines sit at addresses 7 and 9
    task automatic subroutine_links();
        begin_test();
        emit(alu_rri(OP_ADD, 6, 0, 15));
        emit(jsr_rel(7 - 2));
        emit_st(6, slot + 1);
        emit(pc_rel(OP_LEA, 2, 9 - 4));
        emit(jsr_reg(2));
        emit_st(6, slot + 3);
        halt();
        emit_st(7, slot);
        emit(jump(7));
        // returns through a register other than R7
        emit_st(7, slot + 2);
        emit(alu_rri(OP_ADD, 3, 7, 0));
        emit(jump(3));
        expect_write(slot, 16'd2);
        expect_write(slot + 1, 16'd15);
        expect_write(slot + 2, 16'd5);
        expect_write(slot + 3, 16'd15);
        run_program();
    endtask

    task automatic load_store_data();
        logic [15:0] d[8];
        int k0;
        int k1;
        int k2;
        int j1;
        int j2;
        data_state = 32'h3f1c;
        begin_test();
        for (int i = 0; i < 8; i++) begin
            data_state = lcg_next(data_state);
            d[i] = data_state[31:16];
        end
        d[5] = 16'h0000;
        data_state = lcg_next(data_state);
        k0 = int'(data_state[18:16]);
        k1 = int'(data_state[21:19]);
        k2 = int'(data_state[24:22]);
        j1 = int'(data_state[27:25]);
        j2 = (j1 + 1 + int'(data_state[29:28])) % 8;
        for (int i = 0; i < 8; i++) begin
            u_mem_model.mem[DATA_BASE + i] = d[i];
        end
        emit(alu_rri(OP_ADD, 6, 0, 15));
        preset_flags(d[k0]);
        emit(pc_rel(OP_LD, 1, DATA_BASE + k0 - (load_addr + 1)));
        store_result(1, d[k0]);
        flag_checks(d[k0]);
        preset_flags(16'(DATA_BASE));
        emit(pc_rel(OP_LEA, 2, DATA_BASE - (load_addr + 1)));
        store_result(2, 16'(DATA_BASE));
        flag_checks(16'(DATA_BASE));
        preset_flags(d[k1]);
        emit(base_rel(OP_LDR, 3, 2, k1));
        flag_checks(d[k1]);
        emit(pc_rel(OP_LEA, 4, OUT_BASE - (load_addr + 1)));
        emit(base_rel(OP_STR, 3, 4, j1));
        expect_write(OUT_BASE + j1, d[k1]);
        preset_flags(d[k2]);
        emit(base_rel(OP_LDR, 5, 2, k2));
        flag_checks(d[k2]);
        emit(base_rel(OP_STR, 5, 4, j2));
        expect_write(OUT_BASE + j2, d[k2]);
        halt();
        run_program();
    endtask

    task automatic run_suite();
        alu_flags();
        branch_paths();
        subroutine_links();
        load_store_data();
    endtask

    initial begin
        reset_fetch();
        run_suite();
        // same programs again under back-pressure
        random_stalls = 1'b1;
        run_suite();
        $display("No errors");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
source/lc3_pkg.sv
source/lc3_ctrl_if.sv
source/lc3_reg_file.sv
source/lc3_alu_cc.sv
source/lc3_datapath.sv
source/lc3_control.sv
source/lc3_core.sv
testbench/lc3_mem_model.sv
testbench/lc3_core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module lc3_core_tb -f list.f -o lc3_core_sim
	./obj_dir/lc3_core_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Errors found" sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
